// File: design/periph_pkg.sv
/*
 * Bus types, address map and register offsets shared by the peripheral subsystem.
 * Design files refer to everything here by scoped name.
 */
package periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Targets behind the demux
  localparam int unsigned NUM_TARGETS = 3;
  localparam int unsigned TGT_SEL_W = $clog2(NUM_TARGETS);
  localparam int unsigned INTR_IDX = 0;
  localparam int unsigned GPIO_IDX = 1;
  localparam int unsigned EXT_IDX = 2;

  // 4 KiB windows on address bits 15:12
  localparam int unsigned WIN_LSB = 12;
  localparam int unsigned WIN_W = 4;
  localparam logic [WIN_W-1:0] INTR_WIN = 4'd0;
  localparam logic [WIN_W-1:0] GPIO_WIN = 4'd1;
  localparam logic [WIN_W-1:0] EXT_WIN = 4'd2;

  localparam logic [WIN_LSB-1:0] INTR_PENDING_OFS = 12'h000;
  localparam logic [WIN_LSB-1:0] INTR_ENABLE_OFS = 12'h004;
  localparam logic [WIN_LSB-1:0] INTR_CLAIM_OFS = 12'h008;
  localparam logic [WIN_LSB-1:0] INTR_MSIP_OFS = 12'h00C;

  localparam logic [WIN_LSB-1:0] GPIO_IN_OFS = 12'h000;
  localparam logic [WIN_LSB-1:0] GPIO_OUT_OFS = 12'h004;
  localparam logic [WIN_LSB-1:0] GPIO_OE_OFS = 12'h008;
  localparam logic [WIN_LSB-1:0] GPIO_IE_OFS = 12'h00C;
  localparam logic [WIN_LSB-1:0] GPIO_STATUS_OFS = 12'h010;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ACCESS,
    BR_RESP
  } bridge_state_e;

  // Byte-lane merge of a register write
  function automatic logic [31:0] apply_wstrb(logic [31:0] old_val, logic [31:0] wdata,
                                              logic [3:0] wstrb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b])
        res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// File: design/obi_to_reg.sv
/*
 * OBI slave to register bus bridge, one transaction in flight at a time.
 * Grant in idle, one register access, then a single rvalid pulse.
 */
module obi_to_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  periph_pkg::reg_rsp_t  reg_rsp_i
);

  periph_pkg::bridge_state_e state_q;
  periph_pkg::bridge_state_e state_d;

  logic        accept;
  logic        done;
  logic        we_q;
  logic [3:0]  be_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic        err_q;

  assign accept = obi_req_i.req && (state_q == periph_pkg::BR_IDLE);
  assign done = (state_q == periph_pkg::BR_ACCESS) && reg_rsp_i.ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_pkg::BR_IDLE: begin
        if (accept)
          state_d = periph_pkg::BR_ACCESS;
      end
      periph_pkg::BR_ACCESS: begin
        // Held here while the target stalls
        if (reg_rsp_i.ready)
          state_d = periph_pkg::BR_RESP;
      end
      periph_pkg::BR_RESP: state_d = periph_pkg::BR_IDLE;
      default: state_d = periph_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::BR_IDLE;
      we_q    <= 1'b0;
      be_q    <= '0;
      addr_q  <= '0;
      wdata_q <= '0;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        we_q    <= obi_req_i.we;
        be_q    <= obi_req_i.be;
        addr_q  <= obi_req_i.addr;
        wdata_q <= obi_req_i.wdata;
      end
      if (done) begin
        rdata_q <= reg_rsp_i.rdata;
        err_q   <= reg_rsp_i.error;
      end
    end
  end

  assign obi_resp_o.gnt    = accept;
  assign obi_resp_o.rvalid = (state_q == periph_pkg::BR_RESP);
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

  assign reg_req_o.valid = (state_q == periph_pkg::BR_ACCESS);
  assign reg_req_o.write = we_q;
  assign reg_req_o.wstrb = be_q;
  assign reg_req_o.addr  = addr_q;
  assign reg_req_o.wdata = wdata_q;

endmodule

// File: design/reg_demux.sv
/*
 * Register bus window decoder and demultiplexer.
 * Steers one access to its target and answers unmapped windows with an error.
 */
module reg_demux (
  input  periph_pkg::reg_req_t                              reg_req_i,
  output periph_pkg::reg_rsp_t                              reg_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_TARGETS-1:0] tgt_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_TARGETS-1:0] tgt_rsp_i
);

  logic [periph_pkg::WIN_W-1:0]     win;
  logic [periph_pkg::TGT_SEL_W-1:0] sel;
  logic                             hit;

  assign win = reg_req_i.addr[periph_pkg::WIN_LSB +: periph_pkg::WIN_W];

  always_comb begin
    hit = 1'b1;
    sel = '0;
    case (win)
      periph_pkg::INTR_WIN: sel = periph_pkg::TGT_SEL_W'(periph_pkg::INTR_IDX);
      periph_pkg::GPIO_WIN: sel = periph_pkg::TGT_SEL_W'(periph_pkg::GPIO_IDX);
      periph_pkg::EXT_WIN:  sel = periph_pkg::TGT_SEL_W'(periph_pkg::EXT_IDX);
      default: hit = 1'b0;
    endcase
  end

  // Every target sees the payload and only the selected one sees valid
  always_comb begin
    for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
      tgt_req_o[t]       = reg_req_i;
      tgt_req_o[t].valid = reg_req_i.valid && hit &&
                           (sel == periph_pkg::TGT_SEL_W'(t));
    end
  end

  always_comb begin
    if (hit) begin
      reg_rsp_o = tgt_rsp_i[sel];
    end else begin
      // Unmapped window answers with an immediate error
      reg_rsp_o.ready = 1'b1;
      reg_rsp_o.error = 1'b1;
      reg_rsp_o.rdata = '0;
    end
  end

endmodule

// File: design/intr_ctrl.sv
/*
 * Reduced PLIC-style interrupt controller with enable, pending, claim and complete.
 * Also holds the software interrupt bit for the core.
 */
module intr_ctrl #(
  parameter int unsigned NUM_SRC = 21
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NUM_SRC-1:0]   intr_src_i,
  output logic                 irq_o,
  output logic                 msip_o
);

  localparam int unsigned ID_W = $clog2(NUM_SRC);

  logic [periph_pkg::WIN_LSB-1:0] ofs;
  logic                           wr_en;
  logic                           rd_en;
  logic [NUM_SRC-1:0]             pending_q;
  logic [NUM_SRC-1:0]             enable_q;
  logic [NUM_SRC-1:0]             in_service_q;
  logic                           msip_q;
  logic                           irq_q;
  logic [NUM_SRC-1:0]             active;
  logic [ID_W-1:0]                claim_id;
  logic [NUM_SRC-1:0]             claim_mask;
  logic [NUM_SRC-1:0]             complete_mask;
  logic [31:0]                    enable_wr;

  assign ofs   = reg_req_i.addr[periph_pkg::WIN_LSB-1:0];
  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign rd_en = reg_req_i.valid && !reg_req_i.write;

  assign active    = pending_q & enable_q;
  assign enable_wr = periph_pkg::apply_wstrb(32'(enable_q), reg_req_i.wdata, reg_req_i.wstrb);

  // Lowest pending-and-enabled ID wins and 0 means none
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i])
        claim_id = ID_W'(i);
    end
  end

  always_comb begin
    claim_mask = '0;
    if (rd_en && ofs == periph_pkg::INTR_CLAIM_OFS && claim_id != '0)
      claim_mask[claim_id] = 1'b1;
  end

  always_comb begin
    complete_mask = '0;
    if (wr_en && ofs == periph_pkg::INTR_CLAIM_OFS && reg_req_i.wdata < 32'(NUM_SRC))
      complete_mask[reg_req_i.wdata[ID_W-1:0]] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
      irq_q        <= 1'b0;
    end else begin
      // A level source is blocked while its ID is in service
      pending_q    <= (pending_q | (intr_src_i & ~in_service_q)) & ~claim_mask;
      in_service_q <= (in_service_q & ~complete_mask) | claim_mask;
      if (wr_en && ofs == periph_pkg::INTR_ENABLE_OFS)
        enable_q <= enable_wr[NUM_SRC-1:0];
      if (wr_en && ofs == periph_pkg::INTR_MSIP_OFS && reg_req_i.wstrb[0])
        msip_q <= reg_req_i.wdata[0];
      irq_q <= |active;
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      periph_pkg::INTR_PENDING_OFS: reg_rsp_o.rdata = 32'(pending_q);
      periph_pkg::INTR_ENABLE_OFS:  reg_rsp_o.rdata = 32'(enable_q);
      periph_pkg::INTR_CLAIM_OFS:   reg_rsp_o.rdata = 32'(claim_id);
      periph_pkg::INTR_MSIP_OFS:    reg_rsp_o.rdata = {31'b0, msip_q};
      default:                      reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule

// File: design/gpio.sv
/*
 * GPIO block with output, output enable and rising-edge interrupt registers.
 * Pins pass a two-flop synchronizer; STATUS is the interrupt vector.
 */
module gpio #(
  parameter int unsigned NUM_GPIO = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NUM_GPIO-1:0]  gpio_i,
  output logic [NUM_GPIO-1:0]  gpio_o,
  output logic [NUM_GPIO-1:0]  gpio_oe_o,
  output logic [NUM_GPIO-1:0]  intr_o
);

  logic [periph_pkg::WIN_LSB-1:0] ofs;
  logic                           wr_en;
  logic [NUM_GPIO-1:0]            sync1_q;
  logic [NUM_GPIO-1:0]            sync2_q;
  logic [NUM_GPIO-1:0]            prev_q;
  logic [NUM_GPIO-1:0]            out_q;
  logic [NUM_GPIO-1:0]            oe_q;
  logic [NUM_GPIO-1:0]            ie_q;
  logic [NUM_GPIO-1:0]            status_q;
  logic [NUM_GPIO-1:0]            rise;
  logic [NUM_GPIO-1:0]            status_clr;
  logic [31:0]                    out_wr;
  logic [31:0]                    oe_wr;
  logic [31:0]                    ie_wr;
  logic [31:0]                    clr_wr;

  assign ofs   = reg_req_i.addr[periph_pkg::WIN_LSB-1:0];
  assign wr_en = reg_req_i.valid && reg_req_i.write;

  assign out_wr = periph_pkg::apply_wstrb(32'(out_q), reg_req_i.wdata, reg_req_i.wstrb);
  assign oe_wr  = periph_pkg::apply_wstrb(32'(oe_q), reg_req_i.wdata, reg_req_i.wstrb);
  assign ie_wr  = periph_pkg::apply_wstrb(32'(ie_q), reg_req_i.wdata, reg_req_i.wstrb);
  // W1C only on strobed lanes
  assign clr_wr = periph_pkg::apply_wstrb('0, reg_req_i.wdata, reg_req_i.wstrb);

  assign rise = sync2_q & ~prev_q;
  assign status_clr = (wr_en && ofs == periph_pkg::GPIO_STATUS_OFS) ?
                      clr_wr[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      out_q    <= '0;
      oe_q     <= '0;
      ie_q     <= '0;
      status_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & ie_q);
      if (wr_en && ofs == periph_pkg::GPIO_OUT_OFS)
        out_q <= out_wr[NUM_GPIO-1:0];
      if (wr_en && ofs == periph_pkg::GPIO_OE_OFS)
        oe_q <= oe_wr[NUM_GPIO-1:0];
      if (wr_en && ofs == periph_pkg::GPIO_IE_OFS)
        ie_q <= ie_wr[NUM_GPIO-1:0];
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      periph_pkg::GPIO_IN_OFS:     reg_rsp_o.rdata = 32'(sync2_q);
      periph_pkg::GPIO_OUT_OFS:    reg_rsp_o.rdata = 32'(out_q);
      periph_pkg::GPIO_OE_OFS:     reg_rsp_o.rdata = 32'(oe_q);
      periph_pkg::GPIO_IE_OFS:     reg_rsp_o.rdata = 32'(ie_q);
      periph_pkg::GPIO_STATUS_OFS: reg_rsp_o.rdata = 32'(status_q);
      default:                     reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = status_q;

endmodule

// File: design/peripheral_subsystem.sv
/*
 * Peripheral subsystem top: OBI bridge, window demux, interrupt controller and GPIO.
 * The third window leaves the subsystem as an external register port.
 */
module peripheral_subsystem #(
  parameter int unsigned NUM_GPIO = 16,
  parameter int unsigned NEXT_INT = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::obi_req_t  slave_req_i,
  output periph_pkg::obi_resp_t slave_resp_o,
  input  logic [NEXT_INT-1:0]   intr_ext_i,
  output logic                  irq_o,
  output logic                  msip_o,
  input  logic [NUM_GPIO-1:0]   gpio_i,
  output logic [NUM_GPIO-1:0]   gpio_o,
  output logic [NUM_GPIO-1:0]   gpio_oe_o,
  output periph_pkg::reg_req_t  ext_req_o,
  input  periph_pkg::reg_rsp_t  ext_rsp_i
);

  localparam int unsigned NUM_SRC = 1 + NUM_GPIO + NEXT_INT;

  periph_pkg::reg_req_t                              bus_req;
  periph_pkg::reg_rsp_t                              bus_rsp;
  periph_pkg::reg_req_t [periph_pkg::NUM_TARGETS-1:0] tgt_req;
  periph_pkg::reg_rsp_t [periph_pkg::NUM_TARGETS-1:0] tgt_rsp;
  logic [NUM_GPIO-1:0]                               gpio_intr;
  logic [NUM_SRC-1:0]                                intr_vector;

  // ID 0 is reserved as "no interrupt"
  assign intr_vector = {intr_ext_i, gpio_intr, 1'b0};

  assign ext_req_o = tgt_req[periph_pkg::EXT_IDX];
  assign tgt_rsp[periph_pkg::EXT_IDX] = ext_rsp_i;

  obi_to_reg i_obi_to_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (bus_req),
    .reg_rsp_i  (bus_rsp)
  );

  reg_demux i_reg_demux (
    .reg_req_i (bus_req),
    .reg_rsp_o (bus_rsp),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  intr_ctrl #(
    .NUM_SRC (NUM_SRC)
  ) i_intr_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_req_i  (tgt_req[periph_pkg::INTR_IDX]),
    .reg_rsp_o  (tgt_rsp[periph_pkg::INTR_IDX]),
    .intr_src_i (intr_vector),
    .irq_o      (irq_o),
    .msip_o     (msip_o)
  );

  gpio #(
    .NUM_GPIO (NUM_GPIO)
  ) i_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_req_i (tgt_req[periph_pkg::GPIO_IDX]),
    .reg_rsp_o (tgt_rsp[periph_pkg::GPIO_IDX]),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .intr_o    (gpio_intr)
  );

endmodule

// File: testbench/tb_peripheral_subsystem.sv
/*
 * Testbench for the peripheral subsystem: OBI driver, external target responder,
 * register model and self-checks over GPIO, interrupt, external and unmapped windows.
 */
module tb_peripheral_subsystem;

  localparam int NUM_GPIO = 16;
  localparam int NEXT_INT = 4;
  localparam int NUM_SRC = 1 + NUM_GPIO + NEXT_INT;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  localparam int PIN_ROUNDS = 8;
  localparam int EDGE_ROUNDS = 4;
  localparam int EXT_ROUNDS = 12;
  localparam int NUM_TXN = 3 * PIN_ROUNDS + 6 * EDGE_ROUNDS + 4 * NUM_SRC + EXT_ROUNDS + 18;
  localparam logic [31:0] INTR_BASE = 32'h0000_0000;
  localparam logic [31:0] GPIO_BASE = 32'h0000_1000;
  localparam logic [31:0] EXT_BASE = 32'h0000_2000;
  localparam logic [31:0] BAD_BASE = 32'h0000_5000;

  logic clk;
  logic rst_n;
  periph_pkg::obi_req_t  obi_req;
  periph_pkg::obi_resp_t obi_resp;
  periph_pkg::reg_req_t  ext_req;
  periph_pkg::reg_rsp_t  ext_rsp;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic [NEXT_INT-1:0] intr_ext;
  logic irq;
  logic msip;

  integer seed = 22380;
  int check_count = 0;
  int err_count = 0;

  // Register model
  logic [NUM_GPIO-1:0] out_m;
  logic [NUM_GPIO-1:0] oe_m;
  logic [NUM_GPIO-1:0] ie_m;
  logic [NUM_GPIO-1:0] status_m;
  logic [NUM_SRC-1:0]  enable_m;
  logic [NUM_SRC-1:0]  pending_m;
  logic [NUM_SRC-1:0]  in_serv_m;
  logic                msip_m;
  logic [NEXT_INT-1:0] ext_drv;
  logic [31:0]         ext_model [16];
  logic [31:0]         ext_mem [16];

  peripheral_subsystem #(
    .NUM_GPIO (NUM_GPIO),
    .NEXT_INT (NEXT_INT)
  ) dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .slave_req_i  (obi_req),
    .slave_resp_o (obi_resp),
    .intr_ext_i   (intr_ext),
    .irq_o        (irq),
    .msip_o       (msip),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .ext_req_o    (ext_req),
    .ext_rsp_i    (ext_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_val, logic [31:0] new_val,
                                              logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic int lowest_active();
    int id;
    id = 0;
    for (int i = 1; i < NUM_SRC && id == 0; i++) begin
      if (pending_m[i] && enable_m[i])
        id = i;
    end
    return id;
  endfunction

  // Gateway rule applied after the sources have been steady for a while
  function automatic void update_pending();
    pending_m = pending_m | ({ext_drv, status_m, 1'b0} & ~in_serv_m);
  endfunction

  task automatic check_rdata(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_err(string name, periph_pkg::obi_resp_t resp, logic exp);
    check_count++;
    if (resp.err !== exp) begin
      err_count++;
      $display("Fail %s err: got %h expected %h", name, resp.err, exp);
    end
  endtask

  task automatic check_pins(logic [NUM_GPIO-1:0] exp_out, logic [NUM_GPIO-1:0] exp_oe);
    check_count++;
    if (gpio_out !== exp_out || gpio_oe !== exp_oe) begin
      err_count++;
      $display("Fail gpio_o/gpio_oe_o: got %h/%h expected %h/%h", gpio_out, gpio_oe,
               exp_out, exp_oe);
    end
  endtask

  task automatic check_irq(logic exp_irq, logic exp_msip);
    check_count++;
    if (irq !== exp_irq || msip !== exp_msip) begin
      err_count++;
      $display("Fail irq_o/msip_o: got %h/%h expected %h/%h", irq, msip, exp_irq, exp_msip);
    end
  endtask

  task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output periph_pkg::obi_resp_t resp);
    @(posedge clk);
    #2;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(negedge clk);
    while (!obi_resp.gnt)
      @(negedge clk);
    @(posedge clk);
    #2;
    obi_req.req = 1'b0;
    @(negedge clk);
    while (!obi_resp.rvalid)
      @(negedge clk);
    resp = obi_resp;
  endtask

  task automatic write_reg(string name, logic [31:0] addr, logic [3:0] be, logic [31:0] wdata);
    periph_pkg::obi_resp_t resp;
    obi_access(1'b1, be, addr, wdata, resp);
    check_err(name, resp, 1'b0);
  endtask

  task automatic read_check(string name, logic [31:0] addr, logic [31:0] exp);
    periph_pkg::obi_resp_t resp;
    obi_access(1'b0, 4'hF, addr, 32'h0, resp);
    check_rdata(name, resp.rdata, exp);
    check_err(name, resp, 1'b0);
  endtask

  task automatic drive_inputs(logic [NUM_GPIO-1:0] pins, logic [NEXT_INT-1:0] ext);
    @(posedge clk);
    #2;
    gpio_in  = pins;
    intr_ext = ext;
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk);
  endtask

  // External target with 0 to 3 wait states
  initial begin : ext_responder
    logic [31:0] r;
    ext_rsp = '0;
    for (int i = 0; i < 16; i++)
      ext_mem[i] = ~(EXT_BASE + 32'(i) * 4);
    forever begin
      @(posedge clk);
      #2;
      ext_rsp.ready = 1'b0;
      if (ext_req.valid) begin
        check_rdata("ext_req_o.addr", ext_req.addr & 32'hFFFF_F000, EXT_BASE);
        r = rand32();
        repeat (r[1:0]) begin
          @(posedge clk);
          #2;
        end
        if (ext_req.write)
          ext_mem[ext_req.addr[5:2]] = merge_bytes(ext_mem[ext_req.addr[5:2]], ext_req.wdata,
                                                   ext_req.wstrb);
        ext_rsp.rdata = ext_req.write ? 32'h0 : ext_mem[ext_req.addr[5:2]];
        ext_rsp.ready = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_TXN));
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] m;
    int id;
    int guard;
    periph_pkg::obi_resp_t resp;
    rst_n = 1'b0;
    obi_req = '0;
    gpio_in = '0;
    intr_ext = '0;
    {out_m, oe_m, ie_m, status_m, msip_m, ext_drv} = '0;
    {enable_m, pending_m, in_serv_m} = '0;
    for (int i = 0; i < 16; i++)
      ext_model[i] = ~(EXT_BASE + 32'(i) * 4);
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int n = 0; n < PIN_ROUNDS; n++) begin
      r = rand32();
      r2 = rand32();
      if (r2[4]) begin
        write_reg("gpio_out", GPIO_BASE | 32'(periph_pkg::GPIO_OUT_OFS), r2[3:0], r);
        m = merge_bytes(32'(out_m), r, r2[3:0]);
        out_m = m[NUM_GPIO-1:0];
      end else begin
        write_reg("gpio_oe", GPIO_BASE | 32'(periph_pkg::GPIO_OE_OFS), r2[3:0], r);
        m = merge_bytes(32'(oe_m), r, r2[3:0]);
        oe_m = m[NUM_GPIO-1:0];
      end
      check_pins(out_m, oe_m);
      read_check("gpio_out", GPIO_BASE | 32'(periph_pkg::GPIO_OUT_OFS), 32'(out_m));
      read_check("gpio_oe", GPIO_BASE | 32'(periph_pkg::GPIO_OE_OFS), 32'(oe_m));
    end

    for (int n = 0; n < EDGE_ROUNDS; n++) begin
      r = rand32();
      write_reg("gpio_ie", GPIO_BASE | 32'(periph_pkg::GPIO_IE_OFS), 4'hF, r);
      ie_m = r[NUM_GPIO-1:0];
      r2 = rand32();
      drive_inputs(r2[NUM_GPIO-1:0], ext_drv);
      idle(5);
      status_m = status_m | (r2[NUM_GPIO-1:0] & ie_m);
      update_pending();
      read_check("gpio_in", GPIO_BASE | 32'(periph_pkg::GPIO_IN_OFS), 32'(r2[NUM_GPIO-1:0]));
      read_check("gpio_status", GPIO_BASE | 32'(periph_pkg::GPIO_STATUS_OFS), 32'(status_m));
      r = rand32();
      write_reg("gpio_status", GPIO_BASE | 32'(periph_pkg::GPIO_STATUS_OFS), 4'hF, r);
      status_m = status_m & ~r[NUM_GPIO-1:0];
      read_check("gpio_status", GPIO_BASE | 32'(periph_pkg::GPIO_STATUS_OFS), 32'(status_m));
      drive_inputs('0, ext_drv);
      idle(4);
    end

    write_reg("intr_enable", INTR_BASE | 32'(periph_pkg::INTR_ENABLE_OFS), 4'hF, 32'h001F_FFFE);
    enable_m = 21'h1F_FFFE;
    r = rand32();
    ext_drv = r[NEXT_INT-1:0] | 4'h1;
    drive_inputs(gpio_in, ext_drv);
    idle(4);
    update_pending();
    check_irq(|(pending_m & enable_m), msip_m);
    guard = 0;
    while ((pending_m & enable_m) != '0 && guard < NUM_SRC) begin
      id = lowest_active();
      read_check("intr_claim", INTR_BASE | 32'(periph_pkg::INTR_CLAIM_OFS), 32'(id));
      pending_m[id] = 1'b0;
      in_serv_m[id] = 1'b1;
      // Source still high here, so the bit must stay clear while in service
      idle(2);
      update_pending();
      read_check("intr_pending", INTR_BASE | 32'(periph_pkg::INTR_PENDING_OFS), 32'(pending_m));
      if (id <= NUM_GPIO) begin
        write_reg("gpio_status", GPIO_BASE | 32'(periph_pkg::GPIO_STATUS_OFS), 4'hF,
                  32'(1) << (id - 1));
        status_m[id - 1] = 1'b0;
      end else begin
        ext_drv[id - NUM_GPIO - 1] = 1'b0;
        drive_inputs(gpio_in, ext_drv);
      end
      write_reg("intr_complete", INTR_BASE | 32'(periph_pkg::INTR_CLAIM_OFS), 4'hF, 32'(id));
      in_serv_m[id] = 1'b0;
      idle(3);
      update_pending();
      guard++;
    end

    // A source still high at completion turns pending again
    ext_drv = 4'h1;
    drive_inputs(gpio_in, ext_drv);
    idle(4);
    update_pending();
    for (int k = 0; k < 2; k++) begin
      id = lowest_active();
      read_check("intr_claim", INTR_BASE | 32'(periph_pkg::INTR_CLAIM_OFS), 32'(id));
      pending_m[id] = 1'b0;
      in_serv_m[id] = 1'b1;
      write_reg("intr_complete", INTR_BASE | 32'(periph_pkg::INTR_CLAIM_OFS), 4'hF, 32'(id));
      in_serv_m[id] = 1'b0;
      idle(3);
      update_pending();
      read_check("intr_pending", INTR_BASE | 32'(periph_pkg::INTR_PENDING_OFS), 32'(pending_m));
      ext_drv = '0;
      drive_inputs(gpio_in, ext_drv);
    end
    idle(3);
    check_irq(|(pending_m & enable_m), msip_m);

    write_reg("intr_msip", INTR_BASE | 32'(periph_pkg::INTR_MSIP_OFS), 4'hF, 32'h1);
    msip_m = 1'b1;
    check_irq(|(pending_m & enable_m), msip_m);
    write_reg("intr_msip", INTR_BASE | 32'(periph_pkg::INTR_MSIP_OFS), 4'hF, 32'h0);
    msip_m = 1'b0;
    check_irq(|(pending_m & enable_m), msip_m);

    for (int n = 0; n < EXT_ROUNDS; n++) begin
      r = rand32();
      r2 = rand32();
      if (r2[4]) begin
        write_reg("ext_write", EXT_BASE | 32'({r2[3:0], 2'b00}), r2[11:8], r);
        ext_model[r2[3:0]] = merge_bytes(ext_model[r2[3:0]], r, r2[11:8]);
      end else begin
        read_check("ext_rdata", EXT_BASE | 32'({r2[3:0], 2'b00}), ext_model[r2[3:0]]);
      end
    end

    // Window 5 offsets that alias live registers in the mapped windows
    obi_access(1'b1, 4'hF, BAD_BASE | 32'(periph_pkg::GPIO_OUT_OFS), ~32'(out_m), resp);
    check_err("unmapped_write", resp, 1'b1);
    obi_access(1'b1, 4'hF, BAD_BASE, ~ext_model[0], resp);
    check_err("unmapped_write", resp, 1'b1);
    obi_access(1'b0, 4'hF, BAD_BASE | 32'(periph_pkg::INTR_ENABLE_OFS), 32'h0, resp);
    check_err("unmapped_read", resp, 1'b1);
    check_rdata("unmapped_rdata", resp.rdata, 32'h0);
    read_check("gpio_out", GPIO_BASE | 32'(periph_pkg::GPIO_OUT_OFS), 32'(out_m));
    read_check("intr_enable", INTR_BASE | 32'(periph_pkg::INTR_ENABLE_OFS), 32'(enable_m));
    read_check("ext_rdata", EXT_BASE, ext_model[0]);
    check_pins(out_m, oe_m);
    check_irq(|(pending_m & enable_m), msip_m);

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: all.f
design/periph_pkg.sv
design/obi_to_reg.sv
design/reg_demux.sv
design/intr_ctrl.sv
design/gpio.sv
design/peripheral_subsystem.sv
testbench/tb_peripheral_subsystem.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_peripheral_subsystem -f all.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
fi
echo "run.sh: simulation failed"
exit 1
